// ==== design/rob_config.svh ====
/*
 * sizing macros for the reorder buffer back end
 * buffer depth, tag width, data width, register count
 */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// entries in the circular buffer
`define ROB_DEPTH 8
// log2 of ROB_DEPTH
`define ROB_TAG_W 3
// data and address width
`define XLEN 32
// architectural registers and their index width
`define NUM_REGS 32
`define REG_IDX_W 5

`endif

// ==== design/rob_pkg.sv ====
/*
 * shared types for the reorder buffer back end
 * instruction type enum carried with every entry
 */
package rob_pkg;

	// alu and load write a register
	// store waits for its address before it can retire
	// branch retires once ready and writes nothing
	typedef enum logic [1:0] {
		IT_ALU    = 2'd0,
		IT_LOAD   = 2'd1,
		IT_STORE  = 2'd2,
		IT_BRANCH = 2'd3
	} itype_e;

endpackage

// ==== design/reorder_buffer.sv ====
/*
 * reorder buffer
 * circular entry store with in-order dispatch
 * cdb result capture and agu store address capture
 * in-order single-entry commit with registered commit port
 */
`timescale 1ns/1ns
`include "rob_config.svh"

module reorder_buffer import rob_pkg::*; (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              dispatch_en,
	input  itype_e                            dispatch_type,
	input  logic [`REG_IDX_W-1:0]             dispatch_dest,
	input  logic [`XLEN-1:0]                  dispatch_value,
	input  logic                              dispatch_ready,
	input  logic                              cdb_valid,
	input  logic [`ROB_TAG_W-1:0]             cdb_tag,
	input  logic [`XLEN-1:0]                  cdb_data,
	input  logic                              agu_valid,
	input  logic [`ROB_TAG_W-1:0]             agu_tag,
	input  logic [`XLEN-1:0]                  agu_addr,
	output logic [`ROB_TAG_W-1:0]             dispatch_tag,
	output logic                              dispatch_accept,
	output logic                              rob_full,
	output logic [`ROB_DEPTH-1:0]             entry_ready,
	output logic [`ROB_DEPTH-1:0][`XLEN-1:0]  entry_value,
	output logic                              commit_valid,
	output itype_e                            commit_type,
	output logic [`ROB_TAG_W-1:0]             commit_tag,
	output logic [`XLEN-1:0]                  commit_dest,
	output logic [`XLEN-1:0]                  commit_value
);

	// head is the oldest entry, tail the next free slot
	logic [`ROB_TAG_W-1:0] head;
	logic [`ROB_TAG_W-1:0] tail;
	// one extra bit so a full buffer is distinguishable from empty
	logic [`ROB_TAG_W:0]   count;

	logic [`ROB_DEPTH-1:0] ent_valid;
	logic [`ROB_DEPTH-1:0] ent_addr_ready;
	itype_e                ent_type [`ROB_DEPTH];
	// register index for alu/load, memory address for stores
	logic [`XLEN-1:0]      ent_dest [`ROB_DEPTH];

	logic head_commit;
	logic agu_hit;

	assign rob_full        = (count == (`ROB_TAG_W+1)'(`ROB_DEPTH));
	assign dispatch_tag    = tail;
	assign dispatch_accept = dispatch_en && !rob_full;

	// only a live store may take an address off the agu bus
	assign agu_hit = agu_valid && ent_valid[agu_tag] && (ent_type[agu_tag] == IT_STORE);

	// head retires once its data is in and a store also needs its address
	always_comb begin
		head_commit = ent_valid[head] && entry_ready[head];
		if (ent_type[head] == IT_STORE && !ent_addr_ready[head]) begin
			head_commit = 1'b0;
		end
	end

	// pointers, occupancy, valid and ready bits
	always_ff @(posedge clk) begin
		if (!reset) begin
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			ent_valid      <= '0;
			entry_ready    <= '0;
			ent_addr_ready <= '0;
			commit_valid   <= 1'b0;
		end else begin
			commit_valid <= head_commit;
			if (dispatch_accept) begin
				tail <= tail + 1'b1;
			end
			if (head_commit) begin
				head <= head + 1'b1;
			end
			case ({dispatch_accept, head_commit})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				if (dispatch_accept && tail == `ROB_TAG_W'(i)) begin
					// new entry overrides any bus write to the same slot
					ent_valid[i]      <= 1'b1;
					entry_ready[i]    <= dispatch_ready;
					ent_addr_ready[i] <= 1'b0;
				end else begin
					if (head_commit && head == `ROB_TAG_W'(i)) begin
						// ready and value stay put so lookups still forward
						// until the register file takes the result
						ent_valid[i] <= 1'b0;
					end
					if (cdb_valid && ent_valid[i] && cdb_tag == `ROB_TAG_W'(i)) begin
						entry_ready[i] <= 1'b1;
					end
					// cdb and agu touch different fields so both may land
					if (agu_hit && agu_tag == `ROB_TAG_W'(i)) begin
						ent_addr_ready[i] <= 1'b1;
					end
				end
			end
		end
	end

	// entry payload and commit fields
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			if (dispatch_accept && tail == `ROB_TAG_W'(i)) begin
				ent_type[i]    <= dispatch_type;
				ent_dest[i]    <= {{(`XLEN-`REG_IDX_W){1'b0}}, dispatch_dest};
				entry_value[i] <= dispatch_value;
			end else begin
				if (cdb_valid && ent_valid[i] && cdb_tag == `ROB_TAG_W'(i)) begin
					entry_value[i] <= cdb_data;
				end
				// store address replaces the unused destination field
				if (agu_hit && agu_tag == `ROB_TAG_W'(i)) begin
					ent_dest[i] <= agu_addr;
				end
			end
		end
		if (head_commit) begin
			commit_type  <= ent_type[head];
			commit_tag   <= head;
			commit_dest  <= ent_dest[head];
			commit_value <= entry_value[head];
		end
	end

endmodule

// ==== design/arch_regfile.sv ====
/*
 * architectural register file with rename state
 * per-register value, busy bit and producer tag
 * written by the commit port, renamed at dispatch
 */
`timescale 1ns/1ns
`include "rob_config.svh"

module arch_regfile import rob_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rename_en,
	input  logic [`REG_IDX_W-1:0] rename_reg,
	input  logic [`ROB_TAG_W-1:0] rename_tag,
	input  logic                  commit_valid,
	input  itype_e                commit_type,
	input  logic [`ROB_TAG_W-1:0] commit_tag,
	input  logic [`XLEN-1:0]      commit_dest,
	input  logic [`XLEN-1:0]      commit_value,
	input  logic [`REG_IDX_W-1:0] src_reg,
	output logic [`XLEN-1:0]      reg_value,
	output logic                  reg_busy,
	output logic [`ROB_TAG_W-1:0] reg_tag
);

	logic [`XLEN-1:0]      regs     [`NUM_REGS];
	logic [`ROB_TAG_W-1:0] prod_tag [`NUM_REGS];
	logic [`NUM_REGS-1:0]  busy;

	logic [`REG_IDX_W-1:0] wr_reg;
	logic                  wr_en;
	logic                  rn_en;

	// register index sits in the low bits of the destination field
	assign wr_reg = commit_dest[`REG_IDX_W-1:0];
	assign wr_en  = commit_valid && (commit_type == IT_ALU || commit_type == IT_LOAD) &&
		(wr_reg != '0);
	// x0 is hardwired, never renamed
	assign rn_en  = rename_en && (rename_reg != '0);

	always_ff @(posedge clk) begin
		if (!reset) begin
			busy <= '0;
		end else begin
			// only the newest producer may clear the busy bit
			if (wr_en && prod_tag[wr_reg] == commit_tag) begin
				busy[wr_reg] <= 1'b0;
			end
			// a rename at the same edge takes precedence
			if (rn_en) begin
				busy[rename_reg] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_reg] <= commit_value;
		end
		if (rn_en) begin
			prod_tag[rename_reg] <= rename_tag;
		end
	end

	assign reg_value = (src_reg == '0) ? '0 : regs[src_reg];
	assign reg_busy  = busy[src_reg];
	assign reg_tag   = prod_tag[src_reg];

endmodule

// ==== design/operand_read.sv ====
/*
 * operand read
 * picks a source value from the register file or a ready buffer entry
 * otherwise reports the tag of the pending producer
 */
`timescale 1ns/1ns
`include "rob_config.svh"

module operand_read (
	input  logic [`REG_IDX_W-1:0]             src_reg,
	input  logic [`XLEN-1:0]                  reg_value,
	input  logic                              reg_busy,
	input  logic [`ROB_TAG_W-1:0]             reg_tag,
	input  logic [`ROB_DEPTH-1:0]             entry_ready,
	input  logic [`ROB_DEPTH-1:0][`XLEN-1:0]  entry_value,
	output logic                              src_ready,
	output logic [`XLEN-1:0]                  src_value,
	output logic [`ROB_TAG_W-1:0]             src_tag
);

	always_comb begin
		// tag only matters when src_ready is low
		src_tag = reg_tag;
		if (src_reg == '0) begin
			// x0 always reads zero
			src_ready = 1'b1;
			src_value = '0;
		end else if (!reg_busy) begin
			src_ready = 1'b1;
			src_value = reg_value;
		end else if (entry_ready[reg_tag]) begin
			// producer finished but not yet retired so the buffer supplies the value
			src_ready = 1'b1;
			src_value = entry_value[reg_tag];
		end else begin
			src_ready = 1'b0;
			src_value = '0;
		end
	end

endmodule

// ==== design/rob_top.sv ====
/*
 * reorder buffer back end top level
 * reorder buffer and register file side by side
 * operand read stage merging their state
 */
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_top import rob_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dispatch_en,
	input  itype_e                dispatch_type,
	input  logic [`REG_IDX_W-1:0] dispatch_dest,
	input  logic [`XLEN-1:0]      dispatch_value,
	input  logic                  dispatch_ready,
	output logic [`ROB_TAG_W-1:0] dispatch_tag,
	output logic                  rob_full,
	input  logic [`REG_IDX_W-1:0] src_reg,
	output logic                  src_ready,
	output logic [`XLEN-1:0]      src_value,
	output logic [`ROB_TAG_W-1:0] src_tag,
	input  logic                  cdb_valid,
	input  logic [`ROB_TAG_W-1:0] cdb_tag,
	input  logic [`XLEN-1:0]      cdb_data,
	input  logic                  agu_valid,
	input  logic [`ROB_TAG_W-1:0] agu_tag,
	input  logic [`XLEN-1:0]      agu_addr,
	output logic                  commit_valid,
	output itype_e                commit_type,
	output logic [`ROB_TAG_W-1:0] commit_tag,
	output logic [`XLEN-1:0]      commit_dest,
	output logic [`XLEN-1:0]      commit_value
);

	logic                             dispatch_accept;
	logic                             rename_en;
	logic [`ROB_DEPTH-1:0]            entry_ready;
	logic [`ROB_DEPTH-1:0][`XLEN-1:0] entry_value;
	logic [`XLEN-1:0]                 reg_value;
	logic                             reg_busy;
	logic [`ROB_TAG_W-1:0]            reg_tag;

	// accepted register writers claim their destination
	assign rename_en = dispatch_accept && (dispatch_type == IT_ALU || dispatch_type == IT_LOAD);

	reorder_buffer u_reorder_buffer (
		.clk(clk), .reset(reset),
		.dispatch_en(dispatch_en), .dispatch_type(dispatch_type),
		.dispatch_dest(dispatch_dest), .dispatch_value(dispatch_value),
		.dispatch_ready(dispatch_ready),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.agu_valid(agu_valid), .agu_tag(agu_tag), .agu_addr(agu_addr),
		.dispatch_tag(dispatch_tag), .dispatch_accept(dispatch_accept), .rob_full(rob_full),
		.entry_ready(entry_ready), .entry_value(entry_value),
		.commit_valid(commit_valid), .commit_type(commit_type), .commit_tag(commit_tag),
		.commit_dest(commit_dest), .commit_value(commit_value)
	);

	arch_regfile u_arch_regfile (
		.clk(clk), .reset(reset),
		.rename_en(rename_en), .rename_reg(dispatch_dest), .rename_tag(dispatch_tag),
		.commit_valid(commit_valid), .commit_type(commit_type), .commit_tag(commit_tag),
		.commit_dest(commit_dest), .commit_value(commit_value),
		.src_reg(src_reg),
		.reg_value(reg_value), .reg_busy(reg_busy), .reg_tag(reg_tag)
	);

	operand_read u_operand_read (
		.src_reg(src_reg),
		.reg_value(reg_value), .reg_busy(reg_busy), .reg_tag(reg_tag),
		.entry_ready(entry_ready), .entry_value(entry_value),
		.src_ready(src_ready), .src_value(src_value), .src_tag(src_tag)
	);

endmodule

// ==== testbench/rob_tb.sv ====
/*
 * testbench for the reorder buffer back end
 * clock and reset, trace reader and driver
 * commit monitor against a queue of expected commits, timeout
 */
`timescale 1ns/1ns
`include "rob_config.svh"

module rob_tb import rob_pkg::*; ();

	localparam string trace_path = "testbench/rob_trace.txt";

	logic                  clk;
	logic                  reset;
	logic                  dispatch_en;
	itype_e                dispatch_type;
	logic [`REG_IDX_W-1:0] dispatch_dest;
	logic [`XLEN-1:0]      dispatch_value;
	logic                  dispatch_ready;
	logic [`ROB_TAG_W-1:0] dispatch_tag;
	logic                  rob_full;
	logic [`REG_IDX_W-1:0] src_reg;
	logic                  src_ready;
	logic [`XLEN-1:0]      src_value;
	logic [`ROB_TAG_W-1:0] src_tag;
	logic                  cdb_valid;
	logic [`ROB_TAG_W-1:0] cdb_tag;
	logic [`XLEN-1:0]      cdb_data;
	logic                  agu_valid;
	logic [`ROB_TAG_W-1:0] agu_tag;
	logic [`XLEN-1:0]      agu_addr;
	logic                  commit_valid;
	itype_e                commit_type;
	logic [`ROB_TAG_W-1:0] commit_tag;
	logic [`XLEN-1:0]      commit_dest;
	logic [`XLEN-1:0]      commit_value;

	// one expected retirement with fields widened as read from the trace
	typedef struct packed {
		logic [31:0] ctype;
		logic [31:0] tag;
		logic [31:0] dest;
		logic [31:0] value;
	} commit_rec_t;

	commit_rec_t expect_q[$];
	// tags follow dispatched and occupancy is dispatched minus committed
	int dispatched = 0;
	int committed = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int line_no = 0;

	rob_top u_rob_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles with the trace unfinished", cycles);
			fail_stop();
		end
	end

	task automatic fail_stop();
		$display("Simulation failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic compare_values(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			fail_stop();
		end
	endtask

	// limit is every wait in the trace plus 10 cycles per line with margin for reset and drain
	task automatic scan_trace();
		int fd;
		int n;
		string text;
		string op;
		logic [31:0] f1;
		cycle_limit = 30;
		fd = $fopen(trace_path, "r");
		if (fd == 0) begin
			$display("trace file %s could not be opened", trace_path);
			fail_stop();
		end
		while ($fgets(text, fd) != 0) begin
			cycle_limit += 10;
			n = $sscanf(text, "%s %d", op, f1);
			if (n == 2 && op == "W") begin
				cycle_limit += int'(f1);
			end
		end
		$fclose(fd);
	endtask

	// commit_valid is registered and stable one ns after the edge
	task automatic monitor_commit();
		commit_rec_t want;
		if (commit_valid) begin
			if (expect_q.size() == 0) begin
				$display("commit of tag %0d arrived with no commit expected", commit_tag);
				fail_stop();
			end else begin
				want = expect_q.pop_front();
				compare_values($sformatf("commit %0d type", committed), want.ctype,
					{30'd0, commit_type});
				compare_values($sformatf("commit %0d tag", committed), want.tag,
					32'(commit_tag));
				compare_values($sformatf("commit %0d dest", committed), want.dest, commit_dest);
				compare_values($sformatf("commit %0d value", committed), want.value,
					commit_value);
				committed++;
			end
		end
	endtask

	// every cycle after reset passes through here
	task automatic next_cycle();
		@(posedge clk);
		#1;
		dispatch_en = 1'b0;
		cdb_valid   = 1'b0;
		agu_valid   = 1'b0;
		monitor_commit();
		compare_values($sformatf("line %0d rob_full", line_no),
			32'(dispatched - committed == `ROB_DEPTH), 32'(rob_full));
	endtask

	task automatic send_dispatch(input logic [31:0] f1, f2, f3, f4);
		next_cycle();
		// a full buffer drops the strobe so hold off until a slot frees
		while (rob_full) begin
			next_cycle();
		end
		compare_values($sformatf("line %0d dispatch tag", line_no),
			32'(dispatched % `ROB_DEPTH), 32'(dispatch_tag));
		dispatch_en    = 1'b1;
		dispatch_type  = itype_e'(f1[1:0]);
		dispatch_dest  = f2[`REG_IDX_W-1:0];
		dispatch_value = f3;
		dispatch_ready = f4[0];
		dispatched++;
	endtask

	task automatic read_operand(input logic [31:0] f1, f2, f3);
		next_cycle();
		src_reg = f1[`REG_IDX_W-1:0];
		// combinational lookup settles before the falling edge
		@(negedge clk);
		compare_values($sformatf("line %0d r%0d ready", line_no, f1), f2, 32'(src_ready));
		if (f2[0]) begin
			compare_values($sformatf("line %0d r%0d value", line_no, f1), f3, src_value);
		end else begin
			compare_values($sformatf("line %0d r%0d tag", line_no, f1), f3, 32'(src_tag));
		end
	endtask

	initial begin
		int fd;
		int n;
		int drain;
		string text;
		string op;
		logic [31:0] f1, f2, f3, f4;
		reset          = 1'b0;
		dispatch_en    = 1'b0;
		dispatch_type  = IT_ALU;
		dispatch_dest  = '0;
		dispatch_value = '0;
		dispatch_ready = 1'b0;
		src_reg        = '0;
		cdb_valid      = 1'b0;
		cdb_tag        = '0;
		cdb_data       = '0;
		agu_valid      = 1'b0;
		agu_tag        = '0;
		agu_addr       = '0;
		scan_trace();
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;
		fd = $fopen(trace_path, "r");
		while ($fgets(text, fd) != 0) begin
			line_no++;
			n = $sscanf(text, "%s", op);
			if (n == 1 && op != "#") begin
				case (op)
					"D": begin
						n = $sscanf(text, "%s %d %d %h %d", op, f1, f2, f3, f4);
						send_dispatch(f1, f2, f3, f4);
					end
					"C": begin
						n = $sscanf(text, "%s %d %h", op, f1, f2);
						next_cycle();
						cdb_valid = 1'b1;
						cdb_tag   = f1[`ROB_TAG_W-1:0];
						cdb_data  = f2;
					end
					"A": begin
						n = $sscanf(text, "%s %d %h", op, f1, f2);
						next_cycle();
						agu_valid = 1'b1;
						agu_tag   = f1[`ROB_TAG_W-1:0];
						agu_addr  = f2;
					end
					"R": begin
						n = $sscanf(text, "%s %d %d %h", op, f1, f2, f3);
						read_operand(f1, f2, f3);
					end
					"W": begin
						n = $sscanf(text, "%s %d", op, f1);
						repeat (f1) next_cycle();
					end
					"X": begin
						n = $sscanf(text, "%s %d %d %h %h", op, f1, f2, f3, f4);
						expect_q.push_back(commit_rec_t'{f1, f2, f3, f4});
					end
					default: begin
						$display("unknown opcode %s on trace line %0d", op, line_no);
						fail_stop();
					end
				endcase
			end
		end
		$fclose(fd);
		// step until every expected retirement is seen or two buffer turns pass
		drain = 0;
		while (expect_q.size() != 0 && drain < 2 * `ROB_DEPTH) begin
			next_cycle();
			drain++;
		end
		if (expect_q.size() != 0) begin
			$display("%0d expected commits never arrived", expect_q.size());
			fail_stop();
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// ==== src.f ====
+incdir+design
design/rob_pkg.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/operand_read.sv
design/rob_top.sv
testbench/rob_tb.sv

// ==== Makefile ====
# Verilator build and run of the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/rob_trace.txt ====
# D type dest value ready | C tag data | A tag addr | R reg ready value_or_tag | W cycles
# X type tag dest value queues an expected commit; type 0 alu 1 load 2 store 3 branch; hex data
D 0 1 0 0
D 0 2 0 0
D 2 0 55 1
D 0 3 0 0
D 0 3 0 0
D 0 4 44 1
D 1 5 0 0
D 1 6 0 0
R 3 0 4
A 1 100
C 1 22
R 2 1 22
X 0 0 1 11
X 0 1 2 22
C 0 11
W 4
R 1 1 11
X 2 2 200 55
A 2 200
X 0 3 3 33
C 3 33
W 4
R 3 0 4
R 4 1 44
X 0 4 3 34
X 0 5 4 44
C 4 34
W 4
R 3 1 34
D 0 7 0 0
R 7 0 0
X 1 6 5 66
X 1 7 6 67
X 0 0 7 77
C 7 67
C 6 66
C 0 77
R 7 1 77
W 4
R 7 1 77
